//--- sram_test_params.svh
`ifndef SRAM_TEST_PARAMS_SVH
`define SRAM_TEST_PARAMS_SVH

// wishbone bus geometry
`define WB_DATA_W 32
`define WB_ADDR_W 32
`define WB_SEL_W 4

// address bit that splits register space from memory space
// set means the selected bank, clear means the register block
`define MEM_WINDOW_BIT 16

// low address bits that decode a register offset
`define REG_OFFSET_W 8

// bank depths in words
`define BANK0_DEPTH 1024
`define BANK1_DEPTH 256
`define BANK2_DEPTH 512

// shared bank address width
// each bank takes only the low bits it needs, so addresses wrap at depth
`define BANK_ADDR_W 10

// banks on the chip
`define NUM_BANKS 3

`endif

//--- sram_test_cfg_pkg.sv
`include "sram_test_params.svh"

package sram_test_cfg_pkg;

   // register offsets, one 32-bit word each
   // any other offset reads zero and drops writes
   typedef enum logic [`REG_OFFSET_W-1:0] {
      // bank select, read/write
      REG_BANK_SEL = 8'h00,
      // port-1 address, a write also launches a port-1 read
      REG_P1_ADDR  = 8'h04,
      // port-1 result, read only
      REG_P1_DATA  = 8'h08
   } reg_addr_e;

   // bank index written to REG_BANK_SEL
   // 3 selects nothing and memory reads return zero
   typedef logic [1:0] bank_sel_t;

   // kind of wishbone access seen by the controller
   typedef enum logic [1:0] {
      // idle or not accepted this cycle
      ACC_NONE   = 2'd0,
      // register read or write
      ACC_REG    = 2'd1,
      // memory write through port 0
      ACC_MEM_WR = 2'd2,
      // memory read through port 0
      ACC_MEM_RD = 2'd3
   } acc_kind_e;

endpackage

//--- sram_test_mem_pkg.sv
`include "sram_test_params.svh"

package sram_test_mem_pkg;

   // bank 0 payload
   typedef logic [7:0] byte_word_t;

   // bank 1 and bank 2 payload, also the bus word
   typedef logic [`WB_DATA_W-1:0] wide_word_t;

   // per-lane write enable, taken straight from wbs_sel_i
   typedef logic [`WB_SEL_W-1:0] byte_mask_t;

   // active-low chip selects, bit n is bank n
   typedef logic [`NUM_BANKS-1:0] bank_cs_t;

   // word address shared by all banks
   typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;

   // one zero-filled 32-bit word per bank
   // index n holds bank n
   typedef wide_word_t [`NUM_BANKS-1:0] bank_dout_t;

endpackage

//--- sram_macro_model.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// behavioral stand-in for the openram macros
// port 0 is read/write with lane mask, port 1 is read only
module sram_macro_model #(
   parameter type word_t   = sram_test_mem_pkg::wide_word_t,
   parameter int  DEPTH     = 256,
   parameter bit  DUAL_PORT = 1'b1
) (
   input  logic                           clk,
   input  logic                           csb0_i,
   input  logic                           web0_i,
   input  sram_test_mem_pkg::byte_mask_t  wmask0_i,
   input  sram_test_mem_pkg::bank_addr_t  addr0_i,
   input  word_t                          din0_i,
   output word_t                          dout0_o,
   input  logic                           csb1_i,
   input  sram_test_mem_pkg::bank_addr_t  addr1_i,
   output word_t                          dout1_o
);
   import sram_test_mem_pkg::*;

   localparam int WORD_W = $bits(word_t);
   // byte lanes in one word, a byte-wide macro has just lane 0
   localparam int LANES  = (WORD_W + 7) / 8;
   localparam int AW     = $clog2(DEPTH);

   word_t       mem [DEPTH];
   logic [AW-1:0] a0;
   byte_mask_t  lane_we;

   // upper address bits dropped so the bank wraps at its depth
   assign a0 = addr0_i[AW-1:0];

   // no lane written unless web is low
   assign lane_we = web0_i ? '0 : wmask0_i;

   // port 0: masked write or read, never both
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int i = 0; i < LANES; i++) begin
               if (lane_we[i]) begin
                  mem[a0][i*8 +: 8] <= din0_i[i*8 +: 8];
               end
            end
         end else begin
            // read data lands one cycle after the select
            dout0_o <= mem[a0];
         end
      end
   end

   generate
      if (DUAL_PORT) begin : g_port1
         logic [AW-1:0] a1;

         assign a1 = addr1_i[AW-1:0];

         // second port reads only, output holds between reads
         always_ff @(posedge clk) begin
            if (!csb1_i) begin
               dout1_o <= mem[a1];
            end
         end
      end else begin : g_no_port1
         // single-port macro has no second output
         assign dout1_o = '0;
      end
   endgenerate

endmodule

//--- sram_test_regs.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// configuration registers
// bank select, port-1 address and the port-1 read launch
module sram_test_regs (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           reg_we_i,
   input  sram_test_cfg_pkg::reg_addr_e   reg_addr_i,
   input  logic [`WB_DATA_W-1:0]          reg_wdata_i,
   output sram_test_cfg_pkg::bank_sel_t   bank_sel_o,
   output logic [`BANK_ADDR_W-1:0]        p1_addr_o,
   output sram_test_mem_pkg::bank_cs_t    csb1_o,
   output logic                           p1_start_o
);
   import sram_test_cfg_pkg::*;
   import sram_test_mem_pkg::*;

   // port-1 select for the bank chosen right now
   bank_cs_t p1_cs;

   always_comb begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         p1_cs[b] = (bank_sel_o != bank_sel_t'(b));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         bank_sel_o <= '0;
         p1_addr_o  <= '0;
         csb1_o     <= '1;
         p1_start_o <= 1'b0;
      end else begin
         // select and start are single-cycle pulses
         csb1_o     <= '1;
         p1_start_o <= 1'b0;
         if (reg_we_i) begin
            case (reg_addr_i)
               REG_BANK_SEL: begin
                  bank_sel_o <= bank_sel_t'(reg_wdata_i[1:0]);
               end
               REG_P1_ADDR: begin
                  // word index, not a byte address
                  p1_addr_o  <= reg_wdata_i[`BANK_ADDR_W-1:0];
                  csb1_o     <= p1_cs;
                  // capture stage loads the result two cycles on
                  p1_start_o <= 1'b1;
               end
               // P1_DATA is read only, unknown offsets drop the write
               default: begin
               end
            endcase
         end
      end
   end

endmodule

//--- sram_test_ctrl.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// wishbone classic slave
// splits register and memory accesses and times the acknowledge
module sram_test_ctrl (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic                           wbs_cyc_i,
   input  logic                           wbs_stb_i,
   input  logic                           wbs_we_i,
   input  logic [`WB_SEL_W-1:0]           wbs_sel_i,
   input  logic [`WB_ADDR_W-1:0]          wbs_adr_i,
   input  logic [`WB_DATA_W-1:0]          wbs_dat_i,
   output logic                           wbs_ack_o,
   output logic [`WB_DATA_W-1:0]          wbs_dat_o,
   input  sram_test_cfg_pkg::bank_sel_t   bank_sel_i,
   input  logic [`BANK_ADDR_W-1:0]        p1_addr_i,
   input  logic [`WB_DATA_W-1:0]          p1_data_i,
   input  logic [`WB_DATA_W-1:0]          mem_rdata_i,
   output logic                           reg_we_o,
   output sram_test_cfg_pkg::reg_addr_e   reg_addr_o,
   output logic [`WB_DATA_W-1:0]          reg_wdata_o,
   output sram_test_mem_pkg::bank_addr_t  addr0_o,
   output sram_test_mem_pkg::wide_word_t  din0_o,
   output logic                           web0_o,
   output sram_test_mem_pkg::byte_mask_t  wmask0_o,
   output sram_test_mem_pkg::bank_cs_t    csb0_o
);
   import sram_test_cfg_pkg::*;
   import sram_test_mem_pkg::*;

   // cycles from select to valid capture data
   localparam int RD_LAT = 2;
   // cycles until the port-1 result sits in the hold register
   localparam int P1_LAT = 3;

   logic       req;
   logic       in_mem;
   logic       busy;
   logic       p1_wait;
   acc_kind_e  acc_now;
   acc_kind_e  kind_q;
   logic [1:0] lat_cnt_q;
   logic [1:0] p1_cnt_q;
   wide_word_t reg_rdata;

   assign req    = wbs_cyc_i & wbs_stb_i;
   assign in_mem = wbs_adr_i[`MEM_WINDOW_BIT];
   // ack cycle blocks a restart on a still-high strobe
   assign busy    = (kind_q != ACC_NONE) | wbs_ack_o;
   assign p1_wait = (p1_cnt_q != 2'd0);

   // decode once for the whole module
   always_comb begin
      acc_now = ACC_NONE;
      if (req && !busy) begin
         if (in_mem) begin
            acc_now = wbs_we_i ? ACC_MEM_WR : ACC_MEM_RD;
         end else if (!p1_wait) begin
            // register traffic waits out a port-1 read in flight
            acc_now = ACC_REG;
         end
      end
   end

   assign reg_addr_o  = reg_addr_e'(wbs_adr_i[`REG_OFFSET_W-1:0]);
   assign reg_wdata_o = wbs_dat_i;
   assign reg_we_o    = (acc_now == ACC_REG) & wbs_we_i;

   // port 0 follows the bus directly, selected only on the accept cycle
   assign addr0_o  = wbs_adr_i[`BANK_ADDR_W+1:2];
   assign din0_o   = wbs_dat_i;
   assign web0_o   = ~wbs_we_i;
   assign wmask0_o = wbs_sel_i;

   always_comb begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         csb0_o[b] = !(((acc_now == ACC_MEM_RD) || (acc_now == ACC_MEM_WR)) &&
                       (bank_sel_i == bank_sel_t'(b)));
      end
   end

   // register read mux
   always_comb begin
      case (reg_addr_o)
         REG_BANK_SEL: reg_rdata = wide_word_t'(bank_sel_i);
         REG_P1_ADDR:  reg_rdata = wide_word_t'(p1_addr_i);
         REG_P1_DATA:  reg_rdata = p1_data_i;
         default:      reg_rdata = '0;
      endcase
   end

   // read data is payload only
   always_ff @(posedge clk) begin
      if (acc_now == ACC_REG) begin
         wbs_dat_o <= wbs_we_i ? '0 : reg_rdata;
      end else if ((kind_q == ACC_MEM_RD) && (lat_cnt_q == 2'(RD_LAT - 1))) begin
         wbs_dat_o <= mem_rdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wbs_ack_o <= 1'b0;
         kind_q    <= ACC_NONE;
         lat_cnt_q <= '0;
         p1_cnt_q  <= '0;
      end else begin
         wbs_ack_o <= 1'b0;
         // countdown after a port-1 launch
         if (reg_we_o && (reg_addr_o == REG_P1_ADDR)) begin
            p1_cnt_q <= 2'(P1_LAT);
         end else if (p1_wait) begin
            p1_cnt_q <= p1_cnt_q - 2'd1;
         end
         case (kind_q)
            ACC_MEM_RD: begin
               if (lat_cnt_q == 2'(RD_LAT - 1)) begin
                  // an abandoned request gets no ack
                  wbs_ack_o <= req;
                  kind_q    <= ACC_NONE;
               end else begin
                  lat_cnt_q <= lat_cnt_q + 2'd1;
               end
            end
            default: begin
               if (acc_now == ACC_MEM_RD) begin
                  kind_q    <= ACC_MEM_RD;
                  lat_cnt_q <= '0;
               end else if (acc_now != ACC_NONE) begin
                  // register access and memory write finish at once
                  wbs_ack_o <= 1'b1;
               end
            end
         endcase
      end
   end

endmodule

//--- sram_capture.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// registers every bank output each cycle
// picks the active bank and holds the port-1 result
module sram_capture (
   input  logic                           clk,
   input  logic                           rstn,
   input  sram_test_cfg_pkg::bank_sel_t   bank_sel_i,
   input  logic                           p1_start_i,
   input  sram_test_mem_pkg::bank_dout_t  dout0_i,
   input  sram_test_mem_pkg::bank_dout_t  dout1_i,
   output logic [`WB_DATA_W-1:0]          mem_rdata_o,
   output logic [`WB_DATA_W-1:0]          p1_data_o
);
   import sram_test_cfg_pkg::*;
   import sram_test_mem_pkg::*;

   bank_dout_t cap0_q;
   bank_dout_t cap1_q;
   // start pulse aligned with captured port-1 data
   logic [1:0] start_dly_q;
   wide_word_t p1_sel;

   // bank mux, an unmapped select gives zero
   always_comb begin
      mem_rdata_o = '0;
      p1_sel      = '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
         if (bank_sel_i == bank_sel_t'(b)) begin
            mem_rdata_o = cap0_q[b];
            p1_sel      = cap1_q[b];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cap0_q      <= '0;
         cap1_q      <= '0;
         start_dly_q <= '0;
         p1_data_o   <= '0;
      end else begin
         // free-running capture of every bank
         cap0_q      <= dout0_i;
         cap1_q      <= dout1_i;
         start_dly_q <= {start_dly_q[0], p1_start_i};
         if (start_dly_q[1]) begin
            p1_data_o <= p1_sel;
         end
      end
   end

endmodule

//--- sram_testchip_top.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// sram test chip
// wishbone controller and registers around three memory banks
module sram_testchip_top (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  wbs_cyc_i,
   input  logic                  wbs_stb_i,
   input  logic                  wbs_we_i,
   input  logic [`WB_SEL_W-1:0]  wbs_sel_i,
   input  logic [`WB_ADDR_W-1:0] wbs_adr_i,
   input  logic [`WB_DATA_W-1:0] wbs_dat_i,
   output logic                  wbs_ack_o,
   output logic [`WB_DATA_W-1:0] wbs_dat_o
);
   import sram_test_cfg_pkg::*;
   import sram_test_mem_pkg::*;

   // controller to register block
   logic       reg_we;
   reg_addr_e  reg_addr;
   wide_word_t reg_wdata;
   bank_sel_t  bank_sel;
   // port 1 control
   bank_addr_t p1_addr;
   bank_cs_t   csb1;
   logic       p1_start;
   // shared port 0
   bank_addr_t addr0;
   wide_word_t din0;
   logic       web0;
   byte_mask_t wmask0;
   bank_cs_t   csb0;
   // raw bank outputs
   byte_word_t b0_dout0;
   byte_word_t b0_dout1;
   wide_word_t b1_dout0;
   wide_word_t b1_dout1;
   wide_word_t b2_dout0;
   wide_word_t b2_dout1;
   // capture stage results
   wide_word_t mem_rdata;
   wide_word_t p1_data;

   sram_test_ctrl u_ctrl (
      .clk        (clk),
      .rstn       (rstn),
      .wbs_cyc_i  (wbs_cyc_i),
      .wbs_stb_i  (wbs_stb_i),
      .wbs_we_i   (wbs_we_i),
      .wbs_sel_i  (wbs_sel_i),
      .wbs_adr_i  (wbs_adr_i),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_ack_o  (wbs_ack_o),
      .wbs_dat_o  (wbs_dat_o),
      .bank_sel_i (bank_sel),
      .p1_addr_i  (p1_addr),
      .p1_data_i  (p1_data),
      .mem_rdata_i(mem_rdata),
      .reg_we_o   (reg_we),
      .reg_addr_o (reg_addr),
      .reg_wdata_o(reg_wdata),
      .addr0_o    (addr0),
      .din0_o     (din0),
      .web0_o     (web0),
      .wmask0_o   (wmask0),
      .csb0_o     (csb0)
   );

   sram_test_regs u_regs (
      .clk        (clk),
      .rstn       (rstn),
      .reg_we_i   (reg_we),
      .reg_addr_i (reg_addr),
      .reg_wdata_i(reg_wdata),
      .bank_sel_o (bank_sel),
      .p1_addr_o  (p1_addr),
      .csb1_o     (csb1),
      .p1_start_o (p1_start)
   );

   // byte bank zero-filled to the bus width
   sram_capture u_capture (
      .clk        (clk),
      .rstn       (rstn),
      .bank_sel_i (bank_sel),
      .p1_start_i (p1_start),
      .dout0_i    ({b2_dout0, b1_dout0, {(`WB_DATA_W-8){1'b0}}, b0_dout0}),
      .dout1_i    ({b2_dout1, b1_dout1, {(`WB_DATA_W-8){1'b0}}, b0_dout1}),
      .mem_rdata_o(mem_rdata),
      .p1_data_o  (p1_data)
   );

   // bank 0, 8 x 1024 dual port
   sram_macro_model #(
      .word_t   (byte_word_t),
      .DEPTH    (`BANK0_DEPTH),
      .DUAL_PORT(1'b1)
   ) u_bank0 (
      .clk     (clk),
      .csb0_i  (csb0[0]),
      .web0_i  (web0),
      .wmask0_i(wmask0),
      .addr0_i (addr0),
      .din0_i  (din0[7:0]),
      .dout0_o (b0_dout0),
      .csb1_i  (csb1[0]),
      .addr1_i (p1_addr),
      .dout1_o (b0_dout1)
   );

   // bank 1, 32 x 256 dual port
   sram_macro_model #(
      .word_t   (wide_word_t),
      .DEPTH    (`BANK1_DEPTH),
      .DUAL_PORT(1'b1)
   ) u_bank1 (
      .clk     (clk),
      .csb0_i  (csb0[1]),
      .web0_i  (web0),
      .wmask0_i(wmask0),
      .addr0_i (addr0),
      .din0_i  (din0),
      .dout0_o (b1_dout0),
      .csb1_i  (csb1[1]),
      .addr1_i (p1_addr),
      .dout1_o (b1_dout1)
   );

   // bank 2, 32 x 512 single port
   sram_macro_model #(
      .word_t   (wide_word_t),
      .DEPTH    (`BANK2_DEPTH),
      .DUAL_PORT(1'b0)
   ) u_bank2 (
      .clk     (clk),
      .csb0_i  (csb0[2]),
      .web0_i  (web0),
      .wmask0_i(wmask0),
      .addr0_i (addr0),
      .din0_i  (din0),
      .dout0_o (b2_dout0),
      .csb1_i  (csb1[2]),
      .addr1_i (p1_addr),
      .dout1_o (b2_dout1)
   );

endmodule

//--- tb_sram_testchip.sv
`timescale 1ns/1ns
`include "sram_test_params.svh"

// testbench for the sram test chip
// wishbone master tasks, reference copy of every bank, a compare process
module tb_sram_testchip;
   import sram_test_cfg_pkg::*;

   localparam int CLK_PERIOD        = 8;
   localparam int RESET_CYCLES      = 4;
   // about 320 accesses issued, a port-1 read is the longest at under ten cycles
   localparam int MAX_ACCESSES      = 400;
   localparam int CYCLES_PER_ACCESS = 10;
   // margin for idle cycles between accesses
   localparam int TIMEOUT_CYCLES    = MAX_ACCESSES * CYCLES_PER_ACCESS * 5;

   logic                  clk;
   logic                  rstn;
   logic                  wbs_cyc_i;
   logic                  wbs_stb_i;
   logic                  wbs_we_i;
   logic [`WB_SEL_W-1:0]  wbs_sel_i;
   logic [`WB_ADDR_W-1:0] wbs_adr_i;
   logic [`WB_DATA_W-1:0] wbs_dat_i;
   logic                  wbs_ack_o;
   logic [`WB_DATA_W-1:0] wbs_dat_o;

   // reference banks
   logic [7:0]            ref_b0 [`BANK0_DEPTH];
   logic [31:0]           ref_b1 [`BANK1_DEPTH];
   logic [31:0]           ref_b2 [`BANK2_DEPTH];
   // every full-word write, revisited after the bank 3 test
   int                    wr_bank_q [$];
   int                    wr_idx_q [$];
   // reads waiting for the compare process
   string                 chk_name_q [$];
   logic [31:0]           chk_exp_q [$];
   logic [31:0]           chk_act_q [$];
   string                 cur_name;
   logic [31:0]           cur_exp;
   logic [31:0]           cur_act;
   int                    checks_issued;
   int                    checks_done;
   int                    cycle_cnt = 0;
   int                    cur_bank;
   integer                seed;

   sram_testchip_top uut (
      .clk      (clk),
      .rstn     (rstn),
      .wbs_cyc_i(wbs_cyc_i),
      .wbs_stb_i(wbs_stb_i),
      .wbs_we_i (wbs_we_i),
      .wbs_sel_i(wbs_sel_i),
      .wbs_adr_i(wbs_adr_i),
      .wbs_dat_i(wbs_dat_i),
      .wbs_ack_o(wbs_ack_o),
      .wbs_dat_o(wbs_dat_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < TIMEOUT_CYCLES) else begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   // compare at the falling edge, queued reads drained in order
   always @(negedge clk) begin
      while (chk_act_q.size() > 0) begin
         cur_name = chk_name_q.pop_front();
         cur_exp  = chk_exp_q.pop_front();
         cur_act  = chk_act_q.pop_front();
         checks_done++;
         assert (cur_act === cur_exp) else begin
            $display("error: %s expected %08h actual %08h", cur_name, cur_exp, cur_act);
            $display("Test failed");
            $fatal(1, "read data mismatch");
         end
      end
   end

   function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0]  sel);
      logic [31:0] merged;
      merged = old;
      for (int l = 0; l < `WB_SEL_W; l++) begin
         if (sel[l]) begin
            merged[l*8 +: 8] = data[l*8 +: 8];
         end
      end
      return merged;
   endfunction

   // expected read of a bank, address wrapped at the bank depth
   // byte bank zero-extended, bank 2 has no port 1, bank 3 is empty
   function automatic logic [31:0] expected_read(input int bank, input int idx, input bit port1);
      logic [31:0] value;
      case (bank)
         0:       value = {24'd0, ref_b0[idx % `BANK0_DEPTH]};
         1:       value = ref_b1[idx % `BANK1_DEPTH];
         2:       value = port1 ? 32'd0 : ref_b2[idx % `BANK2_DEPTH];
         default: value = 32'd0;
      endcase
      return value;
   endfunction

   task automatic ref_write(input int bank, input int idx, input logic [31:0] data,
                            input logic [3:0] sel);
      case (bank)
         // byte bank has lane 0 only
         0: begin
            if (sel[0]) begin
               ref_b0[idx % `BANK0_DEPTH] = data[7:0];
            end
         end
         1: ref_b1[idx % `BANK1_DEPTH] = merge_lanes(ref_b1[idx % `BANK1_DEPTH], data, sel);
         2: ref_b2[idx % `BANK2_DEPTH] = merge_lanes(ref_b2[idx % `BANK2_DEPTH], data, sel);
         default: begin
         end
      endcase
   endtask

   task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      chk_name_q.push_back(name);
      chk_exp_q.push_back(exp);
      chk_act_q.push_back(act);
      checks_issued++;
   endtask

   // ack sampled mid-cycle, it is a one-cycle pulse
   task automatic wait_ack();
      @(negedge clk);
      while (!wbs_ack_o) begin
         @(negedge clk);
      end
   endtask

   task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
      @(posedge clk);
      #1;
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      wbs_we_i  = 1'b1;
      wbs_sel_i = sel;
      wbs_adr_i = adr;
      wbs_dat_i = dat;
      wait_ack();
      @(posedge clk);
      #1;
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
   endtask

   task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
      @(posedge clk);
      #1;
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      wbs_we_i  = 1'b0;
      wbs_sel_i = 4'hf;
      wbs_adr_i = adr;
      wait_ack();
      dat = wbs_dat_o;
      @(posedge clk);
      #1;
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
   endtask

   // byte address of a word inside the memory window
   function automatic logic [31:0] mem_addr(input int idx);
      return 32'(1 << `MEM_WINDOW_BIT) | 32'((idx % (1 << `BANK_ADDR_W)) << 2);
   endfunction

   task automatic select_bank(input int bank);
      wb_write(32'(REG_BANK_SEL), 32'(bank), 4'hf);
      cur_bank = bank;
   endtask

   task automatic mem_write(input int idx, input logic [31:0] data, input logic [3:0] sel);
      wb_write(mem_addr(idx), data, sel);
      ref_write(cur_bank, idx, data, sel);
      if (sel == 4'hf) begin
         wr_bank_q.push_back(cur_bank);
         wr_idx_q.push_back(idx);
      end
   endtask

   task automatic mem_check(input string name, input int idx);
      logic [31:0] rd;
      wb_read(mem_addr(idx), rd);
      expect_value(name, expected_read(cur_bank, idx, 1'b0), rd);
   endtask

   task automatic reg_check(input string name, input logic [7:0] offset, input logic [31:0] exp);
      logic [31:0] rd;
      wb_read({24'd0, offset}, rd);
      expect_value(name, exp, rd);
   endtask

   // launch through REG_P1_ADDR, result through REG_P1_DATA
   task automatic p1_check(input string name, input int idx);
      logic [31:0] rd;
      wb_write(32'(REG_P1_ADDR), 32'(idx), 4'hf);
      wb_read(32'(REG_P1_DATA), rd);
      expect_value(name, expected_read(cur_bank, idx, 1'b1), rd);
   endtask

   initial begin
      int          idx;
      int          depth;
      int          n;
      logic [31:0] data;
      logic [3:0]  sel;
      seed          = 4;
      clk           = 1'b0;
      rstn          = 1'b0;
      wbs_cyc_i     = 1'b0;
      wbs_stb_i     = 1'b0;
      wbs_we_i      = 1'b0;
      wbs_sel_i     = '0;
      wbs_adr_i     = '0;
      wbs_dat_i     = '0;
      checks_issued = 0;
      checks_done   = 0;
      cur_bank      = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b1;

      // reset values, bank select readback, unmapped offset
      reg_check("bank_sel_reset", REG_BANK_SEL, 32'd0);
      reg_check("p1_addr_reset", REG_P1_ADDR, 32'd0);
      reg_check("p1_data_reset", REG_P1_DATA, 32'd0);
      select_bank(2);
      reg_check("bank_sel_rw", REG_BANK_SEL, 32'd2);
      wb_write(32'h0000_000c, 32'hffff_ffff, 4'hf);
      reg_check("unmapped_reg", 8'h0c, 32'd0);

      // full words on the wide banks, every other read through the alias one depth up
      for (int b = 1; b <= 2; b++) begin
         select_bank(b);
         depth = (b == 1) ? `BANK1_DEPTH : `BANK2_DEPTH;
         for (int i = 0; i < 40; i++) begin
            idx  = $random(seed) & 32'h3ff;
            data = $random(seed);
            mem_write(idx, data, 4'hf);
         end
         for (int i = wr_idx_q.size() - 40; i < wr_idx_q.size(); i++) begin
            idx = (i % 2 == 0) ? wr_idx_q[i] : wr_idx_q[i] + depth;
            mem_check("full_word_wrap", idx);
         end
      end

      // partial lanes over a known word
      for (int b = 0; b <= 2; b++) begin
         select_bank(b);
         for (int i = 0; i < 8; i++) begin
            idx  = $random(seed) & 32'h3ff;
            data = $random(seed);
            mem_write(idx, data, 4'hf);
            data = $random(seed);
            sel  = 4'($random(seed));
            mem_write(idx, data, sel);
            mem_check("partial_lanes", idx);
         end
      end

      // port-1 reads, bank 2 gives zero
      for (int b = 0; b <= 2; b++) begin
         select_bank(b);
         for (int i = 0; i < 4; i++) begin
            idx  = $random(seed) & 32'h3ff;
            data = $random(seed);
            mem_write(idx, data, 4'hf);
            p1_check("port1_read", idx);
         end
      end

      // bank 3 selects nothing
      select_bank(3);
      for (int i = 0; i < 4; i++) begin
         idx = $random(seed) & 32'h3ff;
         mem_check("no_bank_read", idx);
      end
      // writes aimed at words read back below, every bit flipped
      for (int b = 0; b <= 2; b++) begin
         n = 0;
         for (int i = 0; i < wr_idx_q.size() && n < 2; i++) begin
            if (wr_bank_q[i] == b) begin
               mem_write(wr_idx_q[i], ~expected_read(b, wr_idx_q[i], 1'b0), 4'hf);
               n++;
            end
         end
      end
      p1_check("no_bank_port1", idx);

      // earlier contents still in place
      for (int b = 0; b <= 2; b++) begin
         select_bank(b);
         n = 0;
         for (int i = 0; i < wr_idx_q.size() && n < 6; i++) begin
            if (wr_bank_q[i] == b) begin
               mem_check("contents_kept", wr_idx_q[i]);
               n++;
            end
         end
      end

      // let the compare process drain
      repeat (2) @(negedge clk);
      if (checks_done == checks_issued) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("compare process handled %0d of %0d reads", checks_done, checks_issued);
         $display("Test failed");
         $fatal(1, "reads left unchecked");
      end
   end

endmodule

//--- src.f
+incdir+.
sram_test_cfg_pkg.sv
sram_test_mem_pkg.sv
sram_macro_model.sv
sram_test_regs.sv
sram_test_ctrl.sv
sram_capture.sv
sram_testchip_top.sv
tb_sram_testchip.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sram_testchip
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
